/* aesDecryptTop.f */
rtl/aesPkg.sv
rtl/aesControl.sv
rtl/roundCounter.sv
rtl/aesKeySchedule.sv
rtl/aesInvRound.sv
rtl/aesRegisterMap.sv
rtl/aesDecryptTop.sv
tb/aesScoreboard.sv
tb/aesDecryptTb.sv

/* tb/aesDecryptTb.sv */
`timescale 1ns/1ps

module aesDecryptTb;
	import aesPkg::*;

	localparam int pollLimit = 100;	// Status reads before giving up
	localparam int randomOps = 300;

	logic Clk;
	logic rst;
	logic avlRead;
	logic avlWrite;
	logic avlCs;
	logic [3:0] avlByteEn;
	logic [3:0] avlAddr;
	logic [31:0] avlWriteData;
	logic [31:0] avlReadData;
	logic [31:0] exportData;
	aesBlock_t expResult;
	logic resultKnown;
	logic expDone;
	logic doneKnown;
	int errorCount;
	int readCount;
	int timeoutCount;
	int testStart;
	integer seed;
	integer rnd;
	logic [31:0] rdData;
	logic [3:0] rndAddr;
	logic [31:0] rndData;
	logic [3:0] rndBe;

	aesDecryptTop aesDecryptTop_inst (
		.Clk(Clk), .rst(rst),
		.avlRead(avlRead), .avlWrite(avlWrite), .avlCs(avlCs),
		.avlByteEn(avlByteEn), .avlAddr(avlAddr), .avlWriteData(avlWriteData),
		.avlReadData(avlReadData), .exportData(exportData)
	);

	aesScoreboard scoreboard (
		.Clk(Clk), .rst(rst),
		.avlRead(avlRead), .avlWrite(avlWrite), .avlCs(avlCs),
		.avlByteEn(avlByteEn), .avlAddr(avlAddr), .avlWriteData(avlWriteData),
		.avlReadData(avlReadData), .exportData(exportData),
		.expResult(expResult), .resultKnown(resultKnown),
		.expDone(expDone), .doneKnown(doneKnown),
		.errorCount(errorCount), .readCount(readCount)
	);

	initial begin
		Clk = 1'b0;
		forever #5 Clk = ~Clk;	// 10 ns period
	end

	function automatic int totalErrors();
		return errorCount + timeoutCount;
	endfunction

	// One bus write, then an idle cycle
	task automatic writeWord(input logic [3:0] addr, input logic [31:0] data,
		input logic [3:0] be);
		@(negedge Clk);
		avlWrite = 1'b1;
		avlCs = 1'b1;
		avlAddr = addr;
		avlWriteData = data;
		avlByteEn = be;
		@(negedge Clk);
		avlWrite = 1'b0;
		avlCs = 1'b0;
	endtask

	task automatic readWord(input logic [3:0] addr, output logic [31:0] data);
		@(negedge Clk);
		avlRead = 1'b1;
		avlCs = 1'b1;
		avlAddr = addr;
		@(posedge Clk);
		data = avlReadData;	// Zero latency read
		@(negedge Clk);
		avlRead = 1'b0;
		avlCs = 1'b0;
	endtask

	// Poll word 15 until done matches level
	task automatic waitDone(input logic level, input string what);
		logic [31:0] status;
		int polls;
		polls = 0;
		readWord(4'd15, status);
		while ((status[0] !== level) && (polls < pollLimit)) begin
			readWord(4'd15, status);
			polls++;
		end
		if (status[0] !== level) begin
			$display("Timeout at %0t: done never %s after %0d polls", $time, what, polls);
			timeoutCount++;
		end
	endtask

	task automatic runBlock(input aesBlock_t k, input aesBlock_t c, input aesBlock_t p);
		logic [31:0] data;
		for (int i = 0; i < 4; i++) begin
			writeWord(4'(i), k.words[i], 4'hf);
			writeWord(4'(4 + i), c.words[i], 4'hf);
		end
		resultKnown = 1'b0;	// Result words move during the run
		doneKnown = 1'b0;
		writeWord(4'd14, 32'h1, 4'hf);
		waitDone(1'b1, "arrived");
		expResult = p;
		resultKnown = 1'b1;
		expDone = 1'b1;
		doneKnown = 1'b1;
		for (int i = 0; i < 4; i++)
			readWord(4'(8 + i), data);
	endtask

	// Drop start, wait for done to fall, result must stay
	task automatic releaseStart();
		logic [31:0] data;
		writeWord(4'd14, 32'h0, 4'hf);
		doneKnown = 1'b0;
		waitDone(1'b0, "fell");
		expDone = 1'b0;
		doneKnown = 1'b1;
		readWord(4'd15, data);
		for (int i = 0; i < 4; i++)
			readWord(4'(8 + i), data);
	endtask

	task automatic reportTest(input string name);
		$display("Test %s finished, %0d errors", name, totalErrors() - testStart);
		testStart = totalErrors();
	endtask

	initial begin
		seed = 32'h7f9e_ca06;
		rst = 1'b1;
		avlRead = 1'b0;
		avlWrite = 1'b0;
		avlCs = 1'b0;
		avlByteEn = 4'h0;
		avlAddr = 4'h0;
		avlWriteData = 32'h0;
		expResult = '0;
		resultKnown = 1'b1;	// Zero after reset
		expDone = 1'b0;
		doneKnown = 1'b1;
		timeoutCount = 0;
		testStart = 0;
		repeat (16) @(posedge Clk);
		@(negedge Clk);
		rst = 1'b0;

		for (int a = 0; a < 16; a++)
			readWord(4'(a), rdData);
		reportTest("reset readback");

		for (int n = 0; n < randomOps; n++) begin
			rnd = $random(seed);
			rndAddr = rnd[3:0];
			rndBe = rnd[7:4];	// Illegal patterns included
			rndData = $random(seed);
			if (rndAddr == 4'd14)
				rndData[0] = 1'b0;	// Core stays idle
			rnd = $random(seed);
			if (rnd[0])
				writeWord(rndAddr, rndData, rndBe);
			else
				readWord(rndAddr, rdData);
		end
		reportTest("random register traffic");

		runBlock(128'h000102030405060708090a0b0c0d0e0f,
			128'h69c4e0d86a7b0430d8cdb78070b4c55a,
			128'h00112233445566778899aabbccddeeff);
		releaseStart();
		reportTest("first known vector");

		// Stale random key sits in the map before the new one
		for (int i = 0; i < 4; i++)
			writeWord(4'(i), $random(seed), 4'hf);
		runBlock(128'h2b7e151628aed2a6abf7158809cf4f3c,
			128'h3925841d02dc09fbdc118597196a0b32,
			128'h3243f6a8885a308d313198a2e0370734);
		reportTest("second known vector");

		repeat (5) @(negedge Clk);
		readWord(4'd15, rdData);	// Start still high
		readWord(4'd15, rdData);
		releaseStart();
		reportTest("done hold and release");

		$display("Summary: %0d reads, %0d mismatches, %0d timeouts",
			readCount, errorCount, timeoutCount);
		if (totalErrors() == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* tb/aesScoreboard.sv */
`timescale 1ns/1ps

module aesScoreboard (
	input logic Clk,
	input logic rst,
	input logic avlRead,
	input logic avlWrite,
	input logic avlCs,
	input logic [3:0] avlByteEn,
	input logic [3:0] avlAddr,
	input logic [31:0] avlWriteData,
	input logic [31:0] avlReadData,
	input logic [31:0] exportData,
	input aesPkg::aesBlock_t expResult,	// Plaintext expected in words 8-11
	input logic resultKnown,
	input logic expDone,
	input logic doneKnown,
	output int errorCount,
	output int readCount
);

	logic [31:0] model [16];	// Register map as software sees it
	logic [31:0] expected;
	logic [31:0] mask;
	logic checkRead;

	// Full word, either half or one byte, else nothing
	function automatic logic [31:0] byteMask(input logic [3:0] be);
		logic legal;
		legal = (be == 4'b1111) || (be == 4'b1100) || (be == 4'b0011)
			|| ((be != 4'b0000) && ((be & (be - 4'd1)) == 4'b0000));
		if (!legal)
			return 32'h0;
		return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
	endfunction

	always @(posedge Clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++)
				model[i] = 32'h0;
			errorCount = 0;
			readCount = 0;
		end else begin
			for (int i = 0; i < 4; i++)
				model[8 + i] = expResult.words[i];	// Word 8 is the low word
			model[15] = {31'h0, expDone};
			// Conduit from the values before this edge
			expected = {model[0][31:16], model[3][15:0]};
			if (exportData !== expected) begin
				$display("Fail at %0t: exportData expected %08h, actual %08h",
					$time, expected, exportData);
				errorCount++;
			end
			if (avlRead && avlCs) begin
				readCount++;
				checkRead = 1'b1;
				if ((avlAddr >= 4'd8) && (avlAddr <= 4'd11))
					checkRead = resultKnown;	// Not predictable mid-run
				if (avlAddr == 4'd15)
					checkRead = doneKnown;
				if (checkRead && (avlReadData !== model[avlAddr])) begin
					$display("Fail at %0t: avlReadData (addr %0d) expected %08h, actual %08h",
						$time, avlAddr, model[avlAddr], avlReadData);
					errorCount++;
				end
			end
			// Writable words only
			if (avlWrite && avlCs && ((avlAddr < 4'd8) || (avlAddr == 4'd14))) begin
				mask = byteMask(avlByteEn);
				model[avlAddr] = (avlWriteData & mask) | (model[avlAddr] & ~mask);
			end
		end
	end

endmodule

/* rtl/aesDecryptTop.sv */
`timescale 1ns/1ps

module aesDecryptTop (
	input logic Clk,
	input logic rst,
	input logic avlRead,
	input logic avlWrite,
	input logic avlCs,
	input logic [3:0] avlByteEn,
	input logic [3:0] avlAddr,
	input logic [31:0] avlWriteData,
	output logic [31:0] avlReadData,
	output logic [31:0] exportData
);
	import aesPkg::*;

	aesBlock_t key;
	aesBlock_t cipherText;
	aesBlock_t plainText;
	aesBlock_t roundKey;
	logic start;
	logic done;
	logic cntClear, cntUp, cntDown;	// Counter strobes
	logic cntLast, cntFirst;
	logic [3:0] count;	// Also selects rcon
	logic keyLoad, keyForward, keyBackward;
	logic stateLoad, addKeyOnly, lastRound;

	aesRegisterMap regMap (
		.Clk(Clk), .rst(rst),
		.avlRead(avlRead), .avlWrite(avlWrite), .avlCs(avlCs),
		.avlByteEn(avlByteEn), .avlAddr(avlAddr), .avlWriteData(avlWriteData),
		.avlReadData(avlReadData), .exportData(exportData),
		.plainText(plainText), .done(done),
		.key(key), .cipherText(cipherText), .start(start)
	);

	aesControl control (
		.Clk(Clk), .rst(rst), .start(start),
		.cntLast(cntLast), .cntFirst(cntFirst),
		.cntClear(cntClear), .cntUp(cntUp), .cntDown(cntDown),
		.keyLoad(keyLoad), .keyForward(keyForward), .keyBackward(keyBackward),
		.stateLoad(stateLoad), .addKeyOnly(addKeyOnly), .lastRound(lastRound),
		.done(done)
	);

	roundCounter counter (
		.Clk(Clk), .rst(rst),
		.cntClear(cntClear), .cntUp(cntUp), .cntDown(cntDown),
		.count(count), .cntLast(cntLast), .cntFirst(cntFirst)
	);

	aesKeySchedule keySchedule (
		.Clk(Clk), .rst(rst), .key(key), .count(count),
		.keyLoad(keyLoad), .keyForward(keyForward), .keyBackward(keyBackward),
		.roundKey(roundKey)
	);

	aesInvRound invRound (
		.Clk(Clk), .rst(rst), .cipherText(cipherText), .roundKey(roundKey),
		.stateLoad(stateLoad), .addKeyOnly(addKeyOnly), .lastRound(lastRound),
		.plainText(plainText)
	);

endmodule

/* rtl/aesRegisterMap.sv */
`timescale 1ns/1ps

module aesRegisterMap (
	input logic Clk,
	input logic rst,
	input logic avlRead,
	input logic avlWrite,
	input logic avlCs,
	input logic [3:0] avlByteEn,
	input logic [3:0] avlAddr,
	input logic [31:0] avlWriteData,
	output logic [31:0] avlReadData,
	output logic [31:0] exportData,
	input aesPkg::aesBlock_t plainText,
	input logic done,
	output aesPkg::aesBlock_t key,
	output aesPkg::aesBlock_t cipherText,
	output logic start
);

	logic [31:0] regFile [16];	// 0-3 key, 4-7 cipher, 8-11 result, 14 start, 15 done
	logic [31:0] mask;
	logic [31:0] mergedData;
	logic writeHit;

	// Legal byte enables, anything else writes nothing
	always_comb begin
		case (avlByteEn)
			4'b1111: mask = 32'hffffffff;
			4'b1100: mask = 32'hffff0000;	// Upper half
			4'b0011: mask = 32'h0000ffff;	// Lower half
			4'b1000: mask = 32'hff000000;
			4'b0100: mask = 32'h00ff0000;
			4'b0010: mask = 32'h0000ff00;
			4'b0001: mask = 32'h000000ff;
			default: mask = 32'h00000000;
		endcase
	end

	assign writeHit = avlWrite && avlCs && ((avlAddr < 4'd8) || (avlAddr == 4'd14));
	assign mergedData = (avlWriteData & mask) | (regFile[avlAddr] & ~mask);	// Keep unmasked bytes

	always_ff @(posedge Clk) begin
		if (rst) begin
			for (int i = 0; i < 16; i++) begin
				regFile[i] <= 32'h0;
			end
		end else begin
			if (writeHit)
				regFile[avlAddr] <= mergedData;
			// Result words follow the core every clock
			for (int i = 0; i < 4; i++) begin
				regFile[8 + i] <= plainText.words[i];
			end
			regFile[12] <= 32'h0;	// Unused
			regFile[13] <= 32'h0;
			regFile[15] <= {31'h0, done};
		end
	end

	assign avlReadData = regFile[avlAddr];	// Zero wait states

	always_comb begin
		for (int i = 0; i < 4; i++) begin
			key.words[i] = regFile[i];
			cipherText.words[i] = regFile[4 + i];
		end
	end

	assign start = regFile[14][0];
	assign exportData = {regFile[0][31:16], regFile[3][15:0]};	// Conduit to the board

	// Host never issues read and write together
	assert property (@(posedge Clk) disable iff (rst) avlCs |-> !(avlRead && avlWrite));

endmodule

/* rtl/aesInvRound.sv */
`timescale 1ns/1ps

module aesInvRound (
	input logic Clk,
	input logic rst,
	input aesPkg::aesBlock_t cipherText,
	input aesPkg::aesBlock_t roundKey,
	input logic stateLoad,
	input logic addKeyOnly,
	input logic lastRound,
	output aesPkg::aesBlock_t plainText
);
	import aesPkg::*;

	aesBlock_t stateReg;
	aesBlock_t shifted;
	aesBlock_t keyed;
	aesBlock_t mixed;
	aesBlock_t roundOut;

	// InvShiftRows, row r rotates right by r
	// FIPS s[r][c] sits at bytes[15 - r - 4c]
	always_comb begin
		for (int c = 0; c < 4; c++) begin
			for (int r = 0; r < 4; r++) begin
				shifted.bytes[15 - r - 4 * c] = stateReg.bytes[15 - r - 4 * ((c + 4 - r) % 4)];
			end
		end
	end

	// InvSubBytes then AddRoundKey
	always_comb begin
		for (int i = 0; i < 16; i++) begin
			keyed.bytes[i] = invSBox[shifted.bytes[i]] ^ roundKey.bytes[i];
		end
	end

	// InvMixColumns, one column at a time
	always_comb begin : invMixColumns
		logic [7:0] a0, a1, a2, a3;
		for (int c = 0; c < 4; c++) begin
			a0 = keyed.bytes[15 - 4 * c];	// Row 0
			a1 = keyed.bytes[14 - 4 * c];
			a2 = keyed.bytes[13 - 4 * c];
			a3 = keyed.bytes[12 - 4 * c];	// Row 3
			mixed.bytes[15 - 4 * c] = gMul(a0, 4'd14) ^ gMul(a1, 4'd11) ^ gMul(a2, 4'd13) ^ gMul(a3, 4'd9);
			mixed.bytes[14 - 4 * c] = gMul(a0, 4'd9) ^ gMul(a1, 4'd14) ^ gMul(a2, 4'd11) ^ gMul(a3, 4'd13);
			mixed.bytes[13 - 4 * c] = gMul(a0, 4'd13) ^ gMul(a1, 4'd9) ^ gMul(a2, 4'd14) ^ gMul(a3, 4'd11);
			mixed.bytes[12 - 4 * c] = gMul(a0, 4'd11) ^ gMul(a1, 4'd13) ^ gMul(a2, 4'd9) ^ gMul(a3, 4'd14);
		end
	end

	assign roundOut = lastRound ? keyed : mixed;	// Final round has no InvMixColumns

	always_ff @(posedge Clk) begin
		if (rst)
			stateReg <= '0;
		else if (stateLoad)
			stateReg <= addKeyOnly ? (cipherText ^ roundKey) : roundOut;
	end

	assign plainText = stateReg;	// Valid once done rises

endmodule

/* rtl/aesKeySchedule.sv */
`timescale 1ns/1ps

module aesKeySchedule (
	input logic Clk,
	input logic rst,
	input aesPkg::aesBlock_t key,
	input logic [3:0] count,
	input logic keyLoad,
	input logic keyForward,
	input logic keyBackward,
	output aesPkg::aesBlock_t roundKey
);
	import aesPkg::*;

	aesBlock_t keyReg;	// Round key with index count
	aesBlock_t nextKey;
	aesBlock_t prevKey;
	logic [31:0] fwdTemp;
	logic [31:0] bwdTemp;

	// FIPS w0..w3 map to words[3]..words[0]
	always_comb begin
		fwdTemp = subWord({keyReg.words[0][23:0], keyReg.words[0][31:24]});	// RotWord
		nextKey.words[3] = keyReg.words[3] ^ fwdTemp ^ {rcon[count], 24'h000000};
		nextKey.words[2] = keyReg.words[2] ^ nextKey.words[3];
		nextKey.words[1] = keyReg.words[1] ^ nextKey.words[2];
		nextKey.words[0] = keyReg.words[0] ^ nextKey.words[1];
	end

	// Undo one step, neighbours first, then the first word
	always_comb begin
		prevKey.words[0] = keyReg.words[0] ^ keyReg.words[1];
		prevKey.words[1] = keyReg.words[1] ^ keyReg.words[2];
		prevKey.words[2] = keyReg.words[2] ^ keyReg.words[3];
		bwdTemp = subWord({prevKey.words[0][23:0], prevKey.words[0][31:24]});
		prevKey.words[3] = keyReg.words[3] ^ bwdTemp ^ {rcon[count - 4'd1], 24'h000000};
	end

	always_ff @(posedge Clk) begin
		if (rst)
			keyReg <= '0;
		else if (keyLoad)
			keyReg <= key;	// Cipher key is round key 0
		else if (keyForward)
			keyReg <= nextKey;
		else if (keyBackward)
			keyReg <= prevKey;
	end

	// During rounds the key one step back is used in the same cycle
	// AddKey still sees round key 10 straight from the register
	assign roundKey = keyBackward ? prevKey : keyReg;

endmodule

/* rtl/roundCounter.sv */
`timescale 1ns/1ps

module roundCounter (
	input logic Clk,
	input logic rst,
	input logic cntClear,
	input logic cntUp,
	input logic cntDown,
	output logic [3:0] count,
	output logic cntLast,
	output logic cntFirst
);

	always_ff @(posedge Clk) begin
		if (rst)
			count <= 4'd0;
		else if (cntClear)
			count <= 4'd0;
		else if (cntUp)
			count <= count + 4'd1;	// Expansion, one key step per cycle
		else if (cntDown)
			count <= count - 4'd1;	// Decryption, 10 down to 1
	end

	assign cntLast = cntUp && (count == 4'd9);	// This edge reaches 10
	assign cntFirst = cntDown && (count == 4'd1);	// Last inverse round

	assert property (@(posedge Clk) disable iff (rst) count <= 4'd10);

endmodule

/* rtl/aesControl.sv */
`timescale 1ns/1ps

module aesControl (
	input logic Clk,
	input logic rst,
	input logic start,
	input logic cntLast,
	input logic cntFirst,
	output logic cntClear,
	output logic cntUp,
	output logic cntDown,
	output logic keyLoad,
	output logic keyForward,
	output logic keyBackward,
	output logic stateLoad,
	output logic addKeyOnly,
	output logic lastRound,
	output logic done
);
	import aesPkg::*;

	ctrlState_t state;
	ctrlState_t nextState;

	always_ff @(posedge Clk) begin
		if (rst)
			state <= Idle;
		else
			state <= nextState;
	end

	always_comb begin
		nextState = state;
		case (state)
			Idle: if (start) nextState = Expand;	// Level start launches a block
			Expand: if (cntLast) nextState = AddKey;	// Round key 10 ready
			AddKey: nextState = Rounds;
			Rounds: if (cntFirst) nextState = Done;	// Tenth round this cycle
			Done: if (!start) nextState = Idle;	// Hold until software drops start
			default: nextState = Idle;
		endcase
	end

	// Idle keeps the counter at zero and tracks the key register
	assign cntClear = (state == Idle);
	assign keyLoad = (state == Idle);	// Last load lands on the Expand entry edge
	assign cntUp = (state == Expand);
	assign keyForward = (state == Expand);
	assign cntDown = (state == Rounds);
	assign keyBackward = (state == Rounds);
	assign stateLoad = (state == AddKey) || (state == Rounds);
	assign addKeyOnly = (state == AddKey);
	assign lastRound = (state == Rounds) && cntFirst;	// Skip InvMixColumns
	assign done = (state == Done);

	// Launch leads to exactly ten expansion cycles and then AddKey
	assert property (@(posedge Clk) disable iff (rst)
		(state == Idle) && start |=> (state == Expand) [*10] ##1 (state == AddKey));

	// Exactly ten inverse rounds before the result is held
	assert property (@(posedge Clk) disable iff (rst)
		(state == AddKey) |=> (state == Rounds) [*10] ##1 done);

endmodule

/* rtl/aesPkg.sv */
package aesPkg;

	// One 128-bit block, seen as register words or as FIPS-197 bytes
	typedef union packed {
		logic [3:0][31:0] words;	// words[3] is the most significant word
		logic [15:0][7:0] bytes;	// bytes[15] is FIPS byte 0
	} aesBlock_t;

	// Core phases
	typedef enum logic [2:0] {
		Idle,
		Expand,	// Forward key expansion up to round key 10
		AddKey,	// Initial AddRoundKey with round key 10
		Rounds,	// Ten inverse rounds
		Done	// Result held until start drops
	} ctrlState_t;

	// Forward S-box, entry 0 leftmost
	localparam logic [0:255][7:0] sBox = {
		128'h637c777bf26b6fc53001672bfed7ab76,
		128'hca82c97dfa5947f0add4a2af9ca472c0,
		128'hb7fd9326363ff7cc34a5e5f171d83115,
		128'h04c723c31896059a071280e2eb27b275,
		128'h09832c1a1b6e5aa0523bd6b329e32f84,
		128'h53d100ed20fcb15b6acbbe394a4c58cf,
		128'hd0efaafb434d338545f9027f503c9fa8,
		128'h51a3408f929d38f5bcb6da2110fff3d2,
		128'hcd0c13ec5f974417c4a77e3d645d1973,
		128'h60814fdc222a908846eeb814de5e0bdb,
		128'he0323a0a4906245cc2d3ac629195e479,
		128'he7c8376d8dd54ea96c56f4ea657aae08,
		128'hba78252e1ca6b4c6e8dd741f4bbd8b8a,
		128'h703eb5664803f60e613557b986c11d9e,
		128'he1f8981169d98e949b1e87e9ce5528df,
		128'h8ca1890dbfe6426841992d0fb054bb16
	};

	// Inverse S-box
	localparam logic [0:255][7:0] invSBox = {
		128'h52096ad53036a538bf40a39e81f3d7fb,
		128'h7ce339829b2fff87348e4344c4dee9cb,
		128'h547b9432a6c2233dee4c950b42fac34e,
		128'h082ea16628d924b2765ba2496d8bd125,
		128'h72f8f66486689816d4a45ccc5d65b692,
		128'h6c704850fdedb9da5e154657a78d9d84,
		128'h90d8ab008cbcd30af7e45805b8b34506,
		128'hd02c1e8fca3f0f02c1afbd0301138a6b,
		128'h3a9111414f67dcea97f2cfcef0b4e673,
		128'h96ac7422e7ad3585e2f937e81c75df6e,
		128'h47f11a711d29c5896fb7620eaa18be1b,
		128'hfc563e4bc6d279209adbc0fe78cd5af4,
		128'h1fdda8338807c731b11210592780ec5f,
		128'h60517fa919b54a0d2de57a9f93c99cef,
		128'ha0e03b4dae2af5b0c8ebbb3c83539961,
		128'h172b047eba77d626e169146355210c7d
	};

	// Round constants for key steps 1 to 10
	localparam logic [0:9][7:0] rcon = {
		8'h01, 8'h02, 8'h04, 8'h08, 8'h10,
		8'h20, 8'h40, 8'h80, 8'h1b, 8'h36
	};

	// Multiply by x in GF(2^8)
	function automatic logic [7:0] xtime(input logic [7:0] b);
		return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
	endfunction

	// Byte times a small constant, shift and add over the four low bits
	function automatic logic [7:0] gMul(input logic [7:0] a, input logic [3:0] c);
		logic [7:0] acc;
		logic [7:0] pow;
		acc = 8'h00;
		pow = a;
		for (int i = 0; i < 4; i++) begin
			if (c[i])
				acc = acc ^ pow;
			pow = xtime(pow);	// Next power of x
		end
		return acc;
	endfunction

	// S-box on each byte of a key word
	function automatic logic [31:0] subWord(input logic [31:0] w);
		return {sBox[w[31:24]], sBox[w[23:16]], sBox[w[15:8]], sBox[w[7:0]]};
	endfunction

endpackage
